//--- src.f
hdl/cn_cfg_pkg.sv
hdl/cn_bus_pkg.sv
hdl/cn_rotate.sv
hdl/cn_sort_lane.sv
hdl/cn_sign_fifo.sv
hdl/cn_restore.sv
hdl/cn_syndrome.sv
hdl/cn_node_top.sv
dv/tb_clock.sv
dv/tb_cn_node.sv

//--- Makefile
# Verilator build of the check-node unit testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_cn_node
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_cn_node.sv
/* directed testbench for the check-node unit with a min-sum reference model
   inputs change on the falling edge, outputs are checked in order on the falling edge */
`default_nettype none

module tb_cn_node
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NORM_FACTOR    = 7;     // eighths
  localparam int NORM_OFFSET    = 1;
  localparam int LATENCY        = 5;     // eop drive to first output
  localparam int TIMEOUT_CYCLES = 2000;  // all six tests with margin

  logic             iclk;
  logic             ireset;
  logic             istart;
  logic             ival;
  cn_strb_t         istrb;
  cn_ctx_t          ictx;
  cn_znode_t        ivnode;
  cn_zbit_t         ivnode_hd;
  logic             ocnode_val;
  logic [IDX_W+3:0] ocnode_addr;
  cn_znode_t        ocnode;
  logic             odecfail;
  logic             obusy;

  integer           seed;
  int               cyc;
  int               checks;
  int               errors;
  logic [IDX_W+3:0] exp_addr;               // next output address
  cn_znode_t        exp_node [$];           // expected messages in order
  int               exp_cyc [$];            // cycle each one must show up in
  cn_znode_t        row_node [MAX_ROW];     // row being built by a test
  cn_zbit_t         row_hd [MAX_ROW];

  tb_clock u_clk (.clk(iclk));

  cn_node_top #(.pNORM_FACTOR(NORM_FACTOR), .pNORM_OFFSET(NORM_OFFSET)) u_dut (
    .iclk(iclk), .ireset(ireset), .istart(istart), .ival(ival), .istrb(istrb),
    .ictx(ictx), .ivnode(ivnode), .ivnode_hd(ivnode_hd), .ocnode_val(ocnode_val),
    .ocnode_addr(ocnode_addr), .ocnode(ocnode), .odecfail(odecfail), .obusy(obusy)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic int sat_mag(input logic [NODE_W-1:0] v);
    int x;
    x = int'($signed(v));
    x = (x < 0) ? -x : x;
    return (x > (1 << MAG_W) - 1) ? (1 << MAG_W) - 1 : x;  // -32 saturates to 31
  endfunction

  function automatic int norm_mag(input int m);
    int p;
    p = (m * NORM_FACTOR) / 8 - NORM_OFFSET;  // m >= 0, so this is the floor
    return (p < 0) ? 0 : p;
  endfunction

  // per check node: min1, its first index, min2 over the other beats, sign product
  task automatic push_expected(input int n, input int shift, input int eop_cyc);
    int                n1 [ZC];
    int                n2 [ZC];
    int                idx [ZC];
    bit                sp [ZC];
    int                m1;
    int                m2;
    int                mg;
    int                src;
    int                v;
    logic [NODE_W-1:0] x;
    cn_znode_t         w;
    for (int i = 0; i < ZC; i++) begin
      src    = (i + shift) % ZC;               // input lane seen by check node i
      m1     = 1 << MAG_W;
      m2     = 1 << MAG_W;
      idx[i] = 0;
      sp[i]  = 1'b0;
      for (int k = 0; k < n; k++) begin
        x     = row_node[k][src];
        mg    = sat_mag(x);
        sp[i] = sp[i] ^ x[NODE_W-1];
        if (mg < m1) begin                     // first index wins on ties
          m1     = mg;
          idx[i] = k;
        end
      end
      for (int k = 0; k < n; k++) begin
        mg = sat_mag(row_node[k][src]);
        if (k != idx[i] && mg < m2) begin
          m2 = mg;
        end
      end
      n1[i] = norm_mag(m1);
      n2[i] = norm_mag(m2);
    end
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < ZC; i++) begin
        src    = (i + shift) % ZC;
        x      = row_node[k][src];
        mg     = (k == idx[i]) ? n2[i] : n1[i];
        v      = (sp[i] ^ x[NODE_W-1]) ? -mg : mg;
        w[src] = NODE_W'(v);                   // rotated back to the input lane
      end
      exp_node.push_back(w);
      exp_cyc.push_back(eop_cyc + LATENCY + k);
    end
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic drive_idle(input int n);
    repeat (n) begin
      @(negedge iclk);
      ival   = 1'b0;
      istrb  = '0;
      istart = 1'b0;
    end
  endtask

  task automatic apply_reset();
    @(negedge iclk);
    ireset = 1'b1;
    ival   = 1'b0;
    istart = 1'b0;
    istrb  = '0;
    exp_node.delete();   // rows in flight are lost with the reset
    exp_cyc.delete();
    repeat (8) @(negedge iclk);
    ireset   = 1'b0;
    exp_addr = '0;
  endtask

  task automatic start_iteration();
    @(negedge iclk);
    ival     = 1'b0;
    istart   = 1'b1;
    exp_addr = '0;   // address restarts with the iteration
    drive_idle(1);
  endtask

  task automatic fill_random(input int n);
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < ZC; i++) begin
        row_node[k][i] = NODE_W'($random(seed));
      end
      row_hd[k] = '0;
    end
  endtask

  // beats back to back, or with random idle cycles inside the row
  task automatic send_row(input int n, input int shift, input bit gaps);
    int eop_cyc;
    for (int k = 0; k < n; k++) begin
      if (gaps && k != 0 && ($random(seed) & 3) == 0) begin
        drive_idle(1);
      end
      @(negedge iclk);
      ival      = 1'b1;
      istrb     = '{sop: (k == 0), eop: (k == n - 1)};
      ictx      = '{shift: SHIFT_W'(shift)};
      ivnode    = row_node[k];
      ivnode_hd = row_hd[k];
      eop_cyc   = cyc;
    end
    push_expected(n, shift, eop_cyc);
  endtask

  task automatic wait_drain();
    do begin
      drive_idle(1);
      @(posedge iclk);   // monitor pops on the other edge
    end while (exp_node.size() != 0);
    drive_idle(1);
  endtask

  task automatic check_level(input logic got, input logic want, input string what);
    checks++;
    assert (got === want) else begin
      $display("Error: t=%0t ns, %s is %b, expected %b", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic report(input string name, input int err0);
    $display("test %-14s %s, %0d errors", name, (errors == err0) ? "ok" : "FAIL", errors - err0);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_single_row();
    int e0;
    e0 = errors;
    start_iteration();
    for (int k = 0; k < 5; k++) begin
      for (int i = 0; i < ZC; i++) begin
        row_node[k][i] = NODE_W'((k * 7 + i * 5) % 29 - 14);
      end
      row_hd[k] = '0;
    end
    row_node[3] = row_node[1];   // ties in every lane
    send_row(5, 0, 1'b0);
    wait_drain();
    report("single_row", e0);
  endtask

  task automatic test_shifts();
    int e0;
    e0 = errors;
    start_iteration();
    for (int s = 0; s < ZC; s++) begin
      fill_random(3 + s % 4);
      send_row(3 + s % 4, s, 1'b0);
      wait_drain();
    end
    report("shifts", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    int len [3];
    e0  = errors;
    len = '{4, 6, 6};
    start_iteration();
    for (int r = 0; r < 3; r++) begin
      fill_random(len[r]);
      send_row(len[r], (r * 3) % ZC, 1'b0);   // next row starts on the next cycle
    end
    wait_drain();
    report("back_to_back", e0);
  endtask

  task automatic test_syndrome();
    int e0;
    e0 = errors;
    start_iteration();
    fill_random(4);
    row_hd[0] = 8'hA5;
    row_hd[1] = 8'h3C;
    row_hd[2] = 8'hA5;
    row_hd[3] = 8'h3C;   // even in every lane
    send_row(4, 2, 1'b0);
    wait_drain();
    check_level(odecfail, 1'b0, "odecfail after even row");
    fill_random(3);
    row_hd[0] = 8'h10;   // lane 4 odd
    send_row(3, 5, 1'b0);
    wait_drain();
    check_level(odecfail, 1'b1, "odecfail after odd row");
    fill_random(2);
    row_hd[0] = 8'h5A;
    row_hd[1] = 8'h5A;
    send_row(2, 1, 1'b0);
    wait_drain();
    check_level(odecfail, 1'b1, "odecfail held");
    start_iteration();
    check_level(odecfail, 1'b0, "odecfail after istart");
    report("syndrome", e0);
  endtask

  task automatic test_reset_busy();
    int e0;
    e0 = errors;
    fill_random(MAX_ROW);
    row_hd[0] = 8'h01;            // one odd lane, odecfail goes high
    send_row(MAX_ROW, 6, 1'b0);
    drive_idle(3);                // replay under way, no output out yet
    apply_reset();                // long row still replaying and stored
    check_level(ocnode_val, 1'b0, "ocnode_val after reset");
    check_level(odecfail, 1'b0, "odecfail after reset");
    check_level(obusy, 1'b0, "obusy after reset");
    fill_random(6);
    send_row(6, 3, 1'b0);
    drive_idle(2);
    check_level(obusy, 1'b1, "obusy with a stored row");
    wait_drain();
    check_level(obusy, 1'b0, "obusy after last output");
    report("reset_busy", e0);
  endtask

  task automatic test_random();
    int e0;
    int n;
    int shift;
    e0 = errors;
    start_iteration();
    for (int r = 0; r < 20; r++) begin
      n     = 2 + $unsigned($random(seed)) % (MAX_ROW - 1);
      shift = $random(seed) & (ZC - 1);
      fill_random(n);
      if (r % 4 == 0) begin
        row_node[n-1][r % ZC] = {1'b1, {MAG_W{1'b0}}};   // most negative value
      end
      send_row(n, shift, 1'b1);
      wait_drain();
    end
    report("random", e0);
  endtask

  // ------------------------------
  // output monitor and cycle limit
  // ------------------------------
  always @(negedge iclk) begin
    cn_znode_t want;
    int        want_cyc;
    if (!ireset && ocnode_val) begin
      checks++;
      assert (exp_node.size() != 0) else begin
        $display("unexpected output at %0t ns, the DUT sent a message that no row asked for",
                 $time);
        errors++;
      end
      if (exp_node.size() != 0) begin
        want     = exp_node.pop_front();
        want_cyc = exp_cyc.pop_front();
        checks   = checks + 2;
        assert (ocnode === want) else begin
          $display("Error: t=%0t ns, ocnode %h, expected %h", $time, ocnode, want);
          errors++;
        end
        assert (ocnode_addr === exp_addr) else begin
          $display("Error: t=%0t ns, ocnode_addr %0d, expected %0d", $time, ocnode_addr,
                   exp_addr);
          errors++;
        end
        assert (cyc == want_cyc) else begin
          $display("Error: t=%0t ns, output in cycle %0d, expected cycle %0d", $time, cyc,
                   want_cyc);
          errors++;
        end
        exp_addr = exp_addr + 1'b1;
      end
    end
  end

  always @(posedge iclk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    ireset    = 1'b1;
    istart    = 1'b0;
    ival      = 1'b0;
    istrb     = '0;
    ictx      = '0;
    ivnode    = '0;
    ivnode_hd = '0;
    seed      = 39;
    cyc       = 0;
    checks    = 0;
    errors    = 0;
    exp_addr  = '0;
    apply_reset();
    test_single_row();
    test_shifts();
    test_back_to_back();
    test_syndrome();
    test_reset_busy();
    test_random();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/* free-running testbench clock, starts low
   period is twice HALF_NS, 4 ns by default */
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 2  // half period in ns
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  always #(HALF_NS) clk = ~clk;  // first rising edge at HALF_NS

endmodule

`default_nettype wire

//--- hdl/cn_node_top.sv
/* min-sum check-node unit, ZC lanes, no back-pressure
   first output of a row 5 cycles after its eop, then one per cycle without gaps */
`default_nettype none

module cn_node_top
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
#(
  parameter int pNORM_FACTOR = 7,
  parameter int pNORM_OFFSET = 1
) (
  input  logic             iclk,
  input  logic             ireset,
  input  logic             istart,
  input  logic             ival,
  input  cn_strb_t         istrb,
  input  cn_ctx_t          ictx,
  input  cn_znode_t        ivnode,
  input  cn_zbit_t         ivnode_hd,
  output logic             ocnode_val,
  output logic [IDX_W+3:0] ocnode_addr,
  output cn_znode_t        ocnode,
  output logic             odecfail,
  output logic             obusy
);

  cn_beat_t      in_beat, rot_beat, rst_beat, out_beat;
  logic [ZC-1:0] sort_done;
  cn_min_t       sort_min [ZC];
  cn_zbit_t      rot_sign;
  cn_zbit_t      fifo_sign;
  cn_ctx_t       fifo_ctx;
  logic          fifo_read, fifo_empty;

  assign in_beat = '{val: ival, strb: istrb, ctx: ictx, node: ivnode, hd: ivnode_hd};

  cn_rotate #(.pRIGHT(0)) u_rot_in (
    .iclk(iclk), .ireset(ireset), .ibeat(in_beat), .obeat(rot_beat)
  );

  // ------------------------------
  // sort, one lane per check node
  // ------------------------------
  for (genvar g = 0; g < ZC; g++) begin : g_sort
    cn_sort_lane #(.pNORM_FACTOR(pNORM_FACTOR), .pNORM_OFFSET(pNORM_OFFSET)) u_sort (
      .iclk(iclk), .ireset(ireset),
      .ival(rot_beat.val), .isop(rot_beat.strb.sop), .ieop(rot_beat.strb.eop),
      .inode(rot_beat.node[g]),
      .odone(sort_done[g]), .omin(sort_min[g])
    );
    assign rot_sign[g] = rot_beat.node[g][NODE_W-1];  // sign only goes to the FIFO
  end

  cn_syndrome u_synd (
    .iclk(iclk), .ireset(ireset), .istart(istart),
    .ival(rot_beat.val), .ieop(rot_beat.strb.eop), .ihd(rot_beat.hd),
    .odecfail(odecfail)
  );

  cn_sign_fifo u_fifo (
    .iclk(iclk), .ireset(ireset), .iclear(istart),
    .iwrite(rot_beat.val), .iwdat(rot_sign), .iwctx(rot_beat.ctx),
    .iread(fifo_read), .ordat(fifo_sign), .orctx(fifo_ctx), .oempty(fifo_empty)
  );

  // lanes finish on the same beat
  cn_restore u_restore (
    .iclk(iclk), .ireset(ireset), .idone(&sort_done), .imin(sort_min),
    .ifsign(fifo_sign), .ifctx(fifo_ctx), .oread(fifo_read), .obeat(rst_beat)
  );

  cn_rotate #(.pRIGHT(1)) u_rot_out (
    .iclk(iclk), .ireset(ireset), .ibeat(rst_beat), .obeat(out_beat)
  );

  assign ocnode_val = out_beat.val;
  assign ocnode     = out_beat.node;

  // output address and busy
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocnode_addr <= '0;
      obusy       <= 1'b0;
    end else begin
      ocnode_addr <= istart ? '0 : ocnode_addr + (IDX_W+4)'(ocnode_val);
      obusy       <= ~fifo_empty;   // a row is stored or being replayed
    end
  end

endmodule

`default_nettype wire

//--- hdl/cn_syndrome.sv
/* per-lane parity of the hard decisions over each row
   odecfail is sticky until istart */
`default_nettype none

module cn_syndrome
  import cn_bus_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     istart,
  input  logic     ival,
  input  logic     ieop,
  input  cn_zbit_t ihd,
  output logic     odecfail
);

  cn_zbit_t par_r;  // running xor per lane

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      par_r    <= '0;
      odecfail <= 1'b0;
    end else if (istart) begin
      par_r    <= '0;
      odecfail <= 1'b0;
    end else if (ival) begin
      if (ieop) begin
        par_r <= '0;                   // next row starts clean
        if (|(par_r ^ ihd)) begin      // any unsatisfied check
          odecfail <= 1'b1;
        end
      end else begin
        par_r <= par_r ^ ihd;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cn_restore.sv
/* replays a stored row and rebuilds one check-node message per beat
   idone must not arrive while a replay still runs, the source timing rule keeps it so */
`default_nettype none

module cn_restore
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     idone,
  input  cn_min_t  imin [ZC],
  input  cn_zbit_t ifsign,   // FIFO head, vnode signs of the replayed beat
  input  cn_ctx_t  ifctx,
  output logic     oread,
  output cn_beat_t obeat
);

  cn_min_t          min_r [ZC];
  logic             active;
  logic [IDX_W-1:0] idx;        // beat being rebuilt
  logic [IDX_W-1:0] last;

  cn_znode_t node_n;
  cn_zbit_t  hd_n;

  logic      val_r;
  cn_strb_t  strb_r;
  cn_ctx_t   ctx_r;
  cn_znode_t node_r;
  cn_zbit_t  hd_r;

  // sort results of the row being replayed
  always_ff @(posedge iclk) begin
    if (idone) begin
      min_r <= imin;
    end
  end

  // ------------------------------
  // replay counter
  // ------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active <= 1'b0;
      idx    <= '0;
      last   <= '0;
    end else if (idone) begin
      active <= 1'b1;
      idx    <= '0;
      last   <= imin[0].count_m1;   // all lanes see the same row length
    end else if (active) begin
      idx <= idx + 1'b1;
      if (idx == last) begin
        active <= 1'b0;
      end
    end
  end

  assign oread = active;  // one pop per rebuilt beat

  // ------------------------------
  // restore lanes
  // ------------------------------
  for (genvar i = 0; i < ZC; i++) begin : g_lane
    logic [MAG_W-1:0]  mag;
    logic              sgn;
    logic [NODE_W-1:0] pos;

    // the min1 position gets min2, all others min1
    assign mag = (idx == min_r[i].min1_idx) ? min_r[i].min2 : min_r[i].min1;
    assign sgn = min_r[i].sign_prod ^ ifsign[i];   // product of the other signs
    assign pos = {1'b0, mag};

    assign node_n[i] = sgn ? -pos : pos;           // zero stays zero
    assign hd_n[i]   = node_n[i][NODE_W-1];
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r <= 1'b0;
    end else begin
      val_r <= active;
    end
  end

  always_ff @(posedge iclk) begin
    strb_r <= '{sop: (idx == '0), eop: (idx == last)};
    ctx_r  <= ifctx;      // shift for the output rotate
    node_r <= node_n;
    hd_r   <= hd_n;
  end

  assign obeat = '{val: val_r, strb: strb_r, ctx: ctx_r, node: node_r, hd: hd_r};

endmodule

`default_nettype wire

//--- hdl/cn_sign_fifo.sv
/* first-word-fall-through register FIFO for vnode signs and block context
   no full check, the row limits keep it below FIFO_DEPTH entries */
`default_nettype none

module cn_sign_fifo
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     iclear,   // drops everything, new iteration
  input  logic     iwrite,
  input  cn_zbit_t iwdat,
  input  cn_ctx_t  iwctx,
  input  logic     iread,
  output cn_zbit_t ordat,
  output cn_ctx_t  orctx,
  output logic     oempty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  typedef struct packed {
    cn_zbit_t sign;
    cn_ctx_t  ctx;
  } entry_t;

  entry_t        mem [FIFO_DEPTH];
  logic [AW-1:0] wptr, rptr;   // wrap on their own, depth is 2^AW
  logic [AW:0]   count;
  logic          rd;

  assign rd     = iread & ~oempty;  // pop on empty is ignored
  assign oempty = (count == '0);

  always_ff @(posedge iclk) begin
    if (iwrite) begin
      mem[wptr] <= '{sign: iwdat, ctx: iwctx};
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (iclear) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr <= wptr + AW'(iwrite);
      rptr <= rptr + AW'(rd);
      case ({iwrite, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // idle or write plus pop
      endcase
    end
  end

  // head word is visible without a read
  assign ordat = mem[rptr].sign;
  assign orctx = mem[rptr].ctx;

endmodule

`default_nettype wire

//--- hdl/cn_sort_lane.sv
/* min-sum sort of one lane, restarts at sop and finalizes at eop
   omin holds until the next eop, odone pulses one cycle after the eop beat */
`default_nettype none

module cn_sort_lane
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
#(
  parameter int pNORM_FACTOR = 7,  // scale in eighths
  parameter int pNORM_OFFSET = 1
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     ival,
  input  logic                     isop,
  input  logic                     ieop,
  input  logic signed [NODE_W-1:0] inode,
  output logic                     odone,
  output cn_min_t                  omin
);

  localparam int MAX_MAG = (1 << MAG_W) - 1;

  logic [MAG_W-1:0] mag;             // saturated |inode|
  logic [MAG_W-1:0] min1_r, min2_r;
  logic [MAG_W-1:0] min1_n, min2_n;
  logic [IDX_W-1:0] idx_r, idx_n;
  logic [IDX_W-1:0] cnt_r, cnt_n;    // index of the current beat
  logic             sign_r, sign_n;

  // floor(m * factor / 8) - offset, clipped to 0 .. MAX_MAG
  function automatic logic [MAG_W-1:0] norm(input logic [MAG_W-1:0] m);
    int p;
    p = (int'(m) * pNORM_FACTOR) >>> 3;
    p = p - pNORM_OFFSET;
    if (p < 0) begin
      p = 0;
    end else if (p > MAX_MAG) begin
      p = MAX_MAG;
    end
    return MAG_W'(p);
  endfunction

  // -2^(NODE_W-1) has no positive twin, it maps to MAX_MAG
  always_comb begin
    if (inode == {1'b1, {MAG_W{1'b0}}}) begin
      mag = '1;
    end else if (inode[NODE_W-1]) begin
      mag = MAG_W'(-inode);
    end else begin
      mag = inode[MAG_W-1:0];
    end
  end

  // ------------------------------
  // running min1/min2 update
  // ------------------------------
  always_comb begin
    if (isop) begin
      cnt_n  = '0;
      min1_n = mag;
      min2_n = '1;                    // nothing seen yet
      idx_n  = '0;
      sign_n = inode[NODE_W-1];
    end else begin
      cnt_n  = cnt_r + 1'b1;
      sign_n = sign_r ^ inode[NODE_W-1];
      min1_n = min1_r;
      min2_n = min2_r;
      idx_n  = idx_r;
      if (mag < min1_r) begin         // strict, so ties keep the first index
        min1_n = mag;
        min2_n = min1_r;
        idx_n  = cnt_n;
      end else if (mag < min2_r) begin
        min2_n = mag;
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      min1_r <= '0;
      min2_r <= '0;
      idx_r  <= '0;
      cnt_r  <= '0;
      sign_r <= 1'b0;
      odone  <= 1'b0;
    end else begin
      odone <= ival & ieop;
      if (ival) begin                 // gaps hold the state
        min1_r <= min1_n;
        min2_r <= min2_n;
        idx_r  <= idx_n;
        cnt_r  <= cnt_n;
        sign_r <= sign_n;
      end
    end
  end

  // final result, taken straight from the eop update
  always_ff @(posedge iclk) begin
    if (ival && ieop) begin
      omin <= '{min1: norm(min1_n), min2: norm(min2_n), min1_idx: idx_n,
                sign_prod: sign_n, count_m1: cnt_n};
    end
  end

endmodule

`default_nettype wire

//--- hdl/cn_rotate.sv
/* one-cycle registered cyclic rotate of node and hd by ctx.shift lanes
   shift is taken from the beat itself and must be below ZC */
`default_nettype none

module cn_rotate
  import cn_cfg_pkg::*;
  import cn_bus_pkg::*;
#(
  parameter bit pRIGHT = 0  // 0 lane i takes lane i+shift, 1 lane i takes lane i-shift
) (
  input  logic     iclk,
  input  logic     ireset,
  input  cn_beat_t ibeat,
  output cn_beat_t obeat
);

  logic      val_r;
  cn_strb_t  strb_r;
  cn_ctx_t   ctx_r;
  cn_znode_t node_r;
  cn_zbit_t  hd_r;

  cn_znode_t node_rot;
  cn_zbit_t  hd_rot;

  // source lane for output lane i
  function automatic int src_lane(input int i, input logic [SHIFT_W-1:0] s);
    if (pRIGHT) begin
      return (i - int'(s) + ZC) % ZC;
    end
    return (i + int'(s)) % ZC;
  endfunction

  always_comb begin
    for (int i = 0; i < ZC; i++) begin
      node_rot[i] = ibeat.node[src_lane(i, ibeat.ctx.shift)];
      hd_rot[i]   = ibeat.hd[src_lane(i, ibeat.ctx.shift)];  // hd follows its lane
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r <= 1'b0;
    end else begin
      val_r <= ibeat.val;
    end
  end

  // payload, only meaningful with val
  always_ff @(posedge iclk) begin
    strb_r <= ibeat.strb;
    ctx_r  <= ibeat.ctx;   // shift kept for the way back
    node_r <= node_rot;
    hd_r   <= hd_rot;
  end

  assign obeat = '{val: val_r, strb: strb_r, ctx: ctx_r, node: node_r, hd: hd_r};

endmodule

`default_nettype wire

//--- hdl/cn_bus_pkg.sv
/* words that travel between the stages of the check-node pipeline
   lane 0 sits in the low bits of every ZC-wide word */
`default_nettype none

package cn_bus_pkg;

  import cn_cfg_pkg::*;

  // beat framing
  typedef struct packed {
    logic sop;  // first beat of a row
    logic eop;  // last beat of a row
  } cn_strb_t;

  // per block context, carried along with the signs
  typedef struct packed {
    logic [SHIFT_W-1:0] shift;  // cyclic shift of the block
  } cn_ctx_t;

  typedef logic [ZC-1:0][NODE_W-1:0] cn_znode_t;  // ZC two's complement messages
  typedef logic [ZC-1:0]             cn_zbit_t;   // hard decisions or signs

  // result of one lane after a whole row
  typedef struct packed {
    logic [MAG_W-1:0] min1;       // normalized smallest magnitude
    logic [MAG_W-1:0] min2;       // normalized second smallest
    logic [IDX_W-1:0] min1_idx;   // beat that held min1, first one on ties
    logic             sign_prod;  // xor of all signs in the row
    logic [IDX_W-1:0] count_m1;   // beats in the row minus one
  } cn_min_t;

  // one beat of the stream
  typedef struct packed {
    logic      val;
    cn_strb_t  strb;
    cn_ctx_t   ctx;
    cn_znode_t node;
    cn_zbit_t  hd;
  } cn_beat_t;

endpackage

`default_nettype wire

//--- hdl/cn_cfg_pkg.sv
/* datapath sizes of the check-node unit
   FIFO_DEPTH must be a power of two and hold two rows of MAX_ROW beats */
`default_nettype none

package cn_cfg_pkg;

  // lane layout
  localparam int ZC      = 8;          // lanes, one check node per lane
  localparam int NODE_W  = 6;          // signed message width
  localparam int MAG_W   = NODE_W - 1; // magnitude after saturated abs

  // rotate amount, must cover 0 .. ZC-1
  localparam int SHIFT_W = 3;

  // row geometry
  localparam int MAX_ROW = 16;         // vnodes per row at most
  localparam int IDX_W   = 4;          // beat index inside a row

  // two rows in flight through the sign store
  localparam int FIFO_DEPTH = 2 * MAX_ROW;

endpackage

`default_nettype wire
